/* pcxt_glue.f */
pcxt_pkg.sv
config_port.sv
clock_enable_gen.sv
reset_sequencer.sv
splash_timer.sv
sound_mixer.sv
sigma_delta_dac.sv
bus_glue.sv
pcxt_glue.sv
tb_pcxt_glue.sv

/* run_sim.sh */
#!/bin/sh
# build and run the pcxt glue testbench with verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module tb_pcxt_glue -f pcxt_glue.f

out=$(./obj_dir/Vtb_pcxt_glue)
echo "$out"

if echo "$out" | grep -q 'All tests passed!'; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

/* tb_pcxt_glue.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_pcxt_glue import pcxt_pkg::*; ();

	//////////////////////////////
	// run lengths
	//////////////////////////////

	localparam int tb_splash_ticks = 20;
	// ce_14m pulses in one full splash
	localparam int splash_len = splash_seconds * tb_splash_ticks;
	// ce_14m pulses per rate window, two ref edges each
	localparam int rate_window = 120;
	localparam int uart_window = 2048;
	// one full dac accumulator period
	localparam int dac_window = 32768;
	// ce_14m comes every 12 cycles with ref toggling every 3
	localparam int test_cycles = 2 * 120 + splash_len * 12 + 100
		+ 4 * (rate_window * 12 + 20) + 2 * (uart_window + 10)
		+ 400 + dac_window + 20 + 120;
	localparam int watchdog_cycles = test_cycles * 6 / 5;

	logic               clk_chipset = 1'b0;
	logic               reset_wire;
	cfg_req_t           cfg;
	logic               cfg_ack;
	logic               ref_clk, opl2_clk, uart_clk;
	logic               biu_done;
	logic signed [15:0] opl2_snd;
	logic               speaker;
	logic [7:0]         tandy_snd;
	logic               ale;
	logic [19:0]        ad_out;
	logic               port_b3;
	logic               joy_swap;
	joy_pair_t          joy_in;
	rate_ce_t           ce;
	logic               ce_uart, turbo, sys_reset, cpu_reset, tandy_mode, audio_bit;
	logic [16:0]        mix;
	logic [15:0]        dac_word;
	logic [19:0]        cpu_address;
	logic [3:0]         port_c_low;
	joy_pair_t          joy_out;

	int          errors = 0;
	int          prop_errors = 0;
	int          splash_pulses;
	int          uart_rises;
	int          ref_rises;
	int          opl2_rises;
	logic [31:0] rng = 32'h570e;

	pcxt_glue #(.splash_ticks(tb_splash_ticks)) uut (.*);

	always #50 clk_chipset = ~clk_chipset;

	// async reference clocks, moved on the falling edge
	initial begin
		int tick;
		tick = 0;
		ref_clk = 1'b0;
		opl2_clk = 1'b0;
		uart_clk = 1'b0;
		uart_rises = 0;
		ref_rises = 0;
		opl2_rises = 0;
		forever begin
			@(negedge clk_chipset);
			tick++;
			if (tick % 3 == 0) begin
				ref_clk <= ~ref_clk;
				if (!ref_clk)
					ref_rises <= ref_rises + 1;
			end
			if (tick % 7 == 0) begin
				opl2_clk <= ~opl2_clk;
				if (!opl2_clk)
					opl2_rises <= opl2_rises + 1;
			end
			if (tick % 2 == 0) begin
				uart_clk <= ~uart_clk;
				// rising edge when it was low
				if (!uart_clk)
					uart_rises <= uart_rises + 1;
			end
		end
	end

	// ce_14m pulses since the last reset release
	always @(negedge clk_chipset) begin
		if (reset_wire)
			splash_pulses <= 0;
		else if (ce.ce_14m)
			splash_pulses <= splash_pulses + 1;
	end

	//////////////////////////////
	// protocol properties
	//////////////////////////////

	ack_follows_req: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		$rose(cfg.req) |=> cfg_ack) else begin
		prop_errors++;
		$display("FAIL: cfg_ack did not rise one cycle after req");
	end

	ack_drops_after_req: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		$fell(cfg.req) |=> !cfg_ack) else begin
		prop_errors++;
		$display("FAIL: cfg_ack did not fall one cycle after req dropped");
	end

	turbo_on_biu_done: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		(turbo != $past(turbo)) |-> $past(biu_done)) else begin
		prop_errors++;
		$display("FAIL: turbo changed without a biu_done pulse");
	end

	//////////////////////////////
	// helpers
	//////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// option word from its bit map
	function automatic logic [31:0] make_word(input logic tandy, mda, skip,
		input logic [1:0] speed, input logic [1:0] uart);
		logic [31:0] w;
		w = '0;
		w[3] = tandy;
		w[4] = mda;
		w[7] = skip;
		w[18:17] = speed;
		w[22:21] = uart;
		return w;
	endfunction

	// opl2 signed, speaker low adds 2^14, tandy times 512
	function automatic logic [16:0] mix_model(input logic signed [15:0] opl2,
		input logic spk, input logic [7:0] tandy);
		int v;
		v = int'(opl2);
		if (!spk)
			v = v + 16384;
		v = v + int'(tandy) * 512;
		return 17'(v);
	endfunction

	task automatic step();
		@(negedge clk_chipset);
	endtask

	task automatic expect_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		assert (actual === expected) else begin
			errors++;
			$display("MISMATCH %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	task automatic expect_near(input string name, input int expected, input int actual,
		input int tol);
		assert (actual >= expected - tol && actual <= expected + tol) else begin
			errors++;
			$display("MISMATCH %s: expected %0d, actual %0d", name, expected, actual);
		end
	endtask

	task automatic expect_true(input string what, input logic cond);
		assert (cond) else begin
			errors++;
			$display("FAIL: %s", what);
		end
	endtask

	// four-phase load, called on a falling edge
	task automatic load_config(input logic [31:0] word);
		cfg.word = word;
		cfg.req = 1'b1;
		step();
		expect_true("cfg_ack high one cycle after req", cfg_ack === 1'b1);
		cfg.req = 1'b0;
		step();
		expect_true("cfg_ack low one cycle after req dropped", cfg_ack === 1'b0);
	endtask

	initial begin
		repeat (watchdog_cycles) @(posedge clk_chipset);
		$display("timeout: run did not finish within %0d cycles", watchdog_cycles);
		$display("Test failures found");
		$finish;
	end

	//////////////////////////////
	// main sequence
	//////////////////////////////

	initial begin
		int          n;
		int          m;
		int          n14;
		int          ncpu;
		int          n7;
		int          n477;
		int          nper;
		int          nopl;
		int          refs0;
		int          opl0;
		int          div;
		int          ones;
		int          rises0;
		logic [16:0] exp_mix;
		logic [19:0] exp_addr;
		logic [7:0]  img;
		joy_pair_t   exp_joy;
		logic        prev_turbo;
		reset_wire = 1'b1;
		cfg = '0;
		biu_done = 1'b0;
		opl2_snd = '0;
		speaker = 1'b1;
		tandy_snd = '0;
		ale = 1'b0;
		ad_out = '0;
		port_b3 = 1'b0;
		joy_swap = 1'b0;
		joy_in = '0;
		repeat (8) @(posedge clk_chipset);
		step();
		reset_wire = 1'b0;
		expect_value("cfg_ack after reset", 64'(1'b0), 64'(cfg_ack));

		// handshake and dip nibbles, tandy loaded during the splash
		for (int md = 1; md >= 0; md--) begin
			load_config(make_word(1'b1, md[0], 1'b0, 2'd0, 2'b00));
			img = (md != 0) ? sw_mda : sw_cga;
			for (int b = 0; b < 2; b++) begin
				port_b3 = b[0];
				step();
				expect_value("port_c_low", 64'((b != 0) ? img[7:4] : img[3:0]),
					64'(port_c_low));
			end
		end

		// both resets held through the splash
		while (splash_pulses < splash_len) begin
			expect_true("sys_reset and cpu_reset high during splash", sys_reset && cpu_reset);
			step();
		end
		n = 0;
		while (sys_reset && n <= reset_stretch_cycles + 2) begin
			step();
			n++;
		end
		expect_true("sys_reset fell within the stretch window", !sys_reset);
		m = 0;
		while (cpu_reset && m <= cpu_reset_delay + 3) begin
			step();
			m++;
		end
		expect_near("cpu_reset delay", cpu_reset_delay + 2, m, 1);
		expect_value("tandy_mode latched", 64'(1'b1), 64'(tandy_mode));

		// second reset, skip the splash
		reset_wire = 1'b1;
		repeat (8) step();
		reset_wire = 1'b0;
		step();
		expect_value("cfg_ack after second reset", 64'(1'b0), 64'(cfg_ack));
		expect_value("port_c_low after reset",
			64'(port_b3 ? sw_cga[7:4] : sw_cga[3:0]), 64'(port_c_low));
		load_config(make_word(1'b0, 1'b0, 1'b1, 2'd0, 2'b00));
		n = 0;
		while (sys_reset && n < reset_stretch_cycles + 4) begin
			step();
			n++;
		end
		expect_true("sys_reset released soon after splash_skip", !sys_reset);
		expect_true("splash cut short by splash_skip", splash_pulses < splash_len / 10);
		m = 0;
		while (cpu_reset && m <= cpu_reset_delay + 3) begin
			step();
			m++;
		end
		expect_true("cpu_reset released after splash_skip", !cpu_reset);
		expect_value("tandy_mode after second reset", 64'(1'b0), 64'(tandy_mode));

		// cpu rate and turbo per speed code
		for (int s = 0; s < 4; s++) begin
			prev_turbo = turbo;
			load_config(make_word(1'b0, 1'b0, 1'b1, 2'(s), 2'b00));
			repeat (3) step();
			expect_value("turbo held before biu_done", 64'(prev_turbo), 64'(turbo));
			biu_done = 1'b1;
			step();
			biu_done = 1'b0;
			expect_value("turbo after biu_done", 64'((s == 1) || (s == 2)), 64'(turbo));
			case (s)
				1: div = div_7m;
				2: div = div_14m;
				default: div = div_4m77;
			endcase
			n14 = 0;
			ncpu = 0;
			n7 = 0;
			n477 = 0;
			nper = 0;
			nopl = 0;
			refs0 = ref_rises;
			opl0 = opl2_rises;
			while (n14 < rate_window) begin
				step();
				if (ce.ce_14m)
					n14++;
				if (ce.ce_cpu)
					ncpu++;
				if (ce.ce_7m)
					n7++;
				if (ce.ce_4m77)
					n477++;
				if (ce.ce_periph)
					nper++;
				if (ce.ce_opl2)
					nopl++;
			end
			expect_near("ce_cpu pulses", 2 * rate_window / div, ncpu, 1);
			// fixed rates against the reference edges seen in the window
			expect_near("ce_14m pulses", (ref_rises - refs0) / div_14m, n14, 1);
			expect_near("ce_7m pulses", (ref_rises - refs0) / div_7m, n7, 1);
			expect_near("ce_4m77 pulses", (ref_rises - refs0) / div_4m77, n477, 1);
			expect_near("ce_periph pulses", (ref_rises - refs0) / div_periph, nper, 1);
			expect_near("ce_opl2 pulses", opl2_rises - opl0, nopl, 1);
		end

		// uart rate, slow then fast
		for (int f = 0; f < 2; f++) begin
			load_config(make_word(1'b0, 1'b0, 1'b1, 2'd0, (f != 0) ? 2'b10 : 2'b00));
			repeat (8) step();
			rises0 = uart_rises;
			n = 0;
			repeat (uart_window) begin
				step();
				if (ce_uart)
					n++;
			end
			m = uart_rises - rises0;
			expect_near((f != 0) ? "ce_uart fast" : "ce_uart slow",
				(f != 0) ? m : m / uart_slow_div, n, 1);
		end

		// mixer, one cycle behind its inputs
		for (int k = 0; k < 200; k++) begin
			rng = xorshift32(rng);
			opl2_snd = rng[15:0];
			speaker = rng[16];
			tandy_snd = rng[31:24];
			exp_mix = mix_model(opl2_snd, speaker, tandy_snd);
			step();
			expect_value("mix", 64'(exp_mix), 64'(mix));
			expect_value("dac_word", 64'(exp_mix >> 1), 64'(dac_word));
		end

		// held level, ones over one accumulator period
		rng = xorshift32(rng);
		opl2_snd = rng[15:0];
		speaker = rng[16];
		tandy_snd = rng[31:24];
		exp_mix = mix_model(opl2_snd, speaker, tandy_snd);
		repeat (4) step();
		ones = 0;
		repeat (dac_window) begin
			step();
			if (audio_bit)
				ones++;
		end
		expect_near("audio_bit density", int'(exp_mix[16:2]), ones, 1);

		// address latch and joystick swap
		exp_addr = '0;
		for (int k = 0; k < 60; k++) begin
			rng = xorshift32(rng);
			ad_out = rng[19:0];
			ale = rng[20];
			joy_swap = rng[21];
			rng = xorshift32(rng);
			joy_in.joy0 = rng;
			rng = xorshift32(rng);
			joy_in.joy1 = rng;
			if (ale)
				exp_addr = ad_out;
			exp_joy = joy_in;
			if (joy_swap) begin
				exp_joy.joy0 = joy_in.joy1;
				exp_joy.joy1 = joy_in.joy0;
			end
			step();
			expect_value("cpu_address", 64'(exp_addr), 64'(cpu_address));
			expect_value("joy_out", 64'(exp_joy), 64'(joy_out));
		end
		ale = 1'b0;
		step();

		$display("check errors: %0d, assertion errors: %0d", errors, prop_errors);
		if (errors == 0 && prop_errors == 0)
			$display("All tests passed!");
		else
			$display("Test failures found");
		$finish;
	end

endmodule

`default_nettype wire

/* pcxt_glue.sv */
`timescale 1ns/10ps
`default_nettype none

module pcxt_glue import pcxt_pkg::*; #(
	parameter int splash_ticks = splash_ticks_default
) (
	input  wire logic               clk_chipset,
	input  wire logic               reset_wire,
	// host config port
	input  wire cfg_req_t           cfg,
	output logic                    cfg_ack,
	// async reference clocks
	input  wire logic               ref_clk,
	input  wire logic               opl2_clk,
	input  wire logic               uart_clk,
	input  wire logic               biu_done,
	// sound sources
	input  wire logic signed [15:0] opl2_snd,
	input  wire logic               speaker,
	input  wire logic [7:0]         tandy_snd,
	// cpu bus side
	input  wire logic               ale,
	input  wire logic [19:0]        ad_out,
	input  wire logic               port_b3,
	input  wire logic               joy_swap,
	input  wire joy_pair_t          joy_in,
	output rate_ce_t                ce,
	output logic                    ce_uart,
	output logic                    turbo,
	output logic                    sys_reset,
	output logic                    cpu_reset,
	output logic                    tandy_mode,
	output logic [mix_width-1:0]    mix,
	output logic [15:0]             dac_word,
	output logic                    audio_bit,
	output logic [19:0]             cpu_address,
	output logic [3:0]              port_c_low,
	output joy_pair_t               joy_out
);

	settings_t settings;
	logic      splash_active;

	//////////////////////////////
	// config and clocking
	//////////////////////////////

	config_port u_config_port (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.cfg         (cfg),
		.cfg_ack     (cfg_ack),
		.settings    (settings)
	);

	clock_enable_gen u_clock_enable_gen (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.ref_clk     (ref_clk),
		.opl2_clk    (opl2_clk),
		.uart_clk    (uart_clk),
		.settings    (settings),
		.biu_done    (biu_done),
		.ce          (ce),
		.ce_uart     (ce_uart),
		.turbo       (turbo)
	);

	// reset chain, splash holds sys reset
	reset_sequencer u_reset_sequencer (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.settings      (settings),
		.splash_active (splash_active),
		.sys_reset     (sys_reset),
		.cpu_reset     (cpu_reset),
		.tandy_mode    (tandy_mode)
	);

	splash_timer #(.splash_ticks(splash_ticks)) u_splash_timer (
		.clk_chipset   (clk_chipset),
		.reset_wire    (reset_wire),
		.ce_14m        (ce.ce_14m),
		.settings      (settings),
		.splash_active (splash_active)
	);

	//////////////////////////////
	// audio and bus
	//////////////////////////////

	sound_mixer u_sound_mixer (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.opl2_snd    (opl2_snd),
		.speaker     (speaker),
		.tandy_snd   (tandy_snd),
		.mix         (mix),
		.dac_word    (dac_word)
	);

	// dac level is mix over 4
	sigma_delta_dac u_sigma_delta_dac (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.level       (mix[mix_width-1:2]),
		.bitstream   (audio_bit)
	);

	bus_glue u_bus_glue (
		.clk_chipset (clk_chipset),
		.reset_wire  (reset_wire),
		.ale         (ale),
		.ad_out      (ad_out),
		.port_b3     (port_b3),
		.settings    (settings),
		.joy_swap    (joy_swap),
		.joy_in      (joy_in),
		.cpu_address (cpu_address),
		.port_c_low  (port_c_low),
		.joy_out     (joy_out)
	);

endmodule

`default_nettype wire

/* bus_glue.sv */
`timescale 1ns/10ps
`default_nettype none

module bus_glue import pcxt_pkg::*; (
	input  wire logic        clk_chipset,
	input  wire logic        reset_wire,
	input  wire logic        ale,
	input  wire logic [19:0] ad_out,
	input  wire logic        port_b3,
	input  wire settings_t   settings,
	input  wire logic        joy_swap,
	input  wire joy_pair_t   joy_in,
	output logic [19:0]      cpu_address,
	output logic [3:0]       port_c_low,
	output joy_pair_t        joy_out
);

	logic [7:0] sw;

	// address latch, follows ale
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			cpu_address <= '0;
		else if (ale)
			cpu_address <= ad_out;
	end

	// dip image by display type
	assign sw = settings.mda ? sw_mda : sw_cga;
	// ppi port b bit 3 picks the nibble
	assign port_c_low = port_b3 ? sw[7:4] : sw[3:0];

	// joystick swap
	always_comb begin
		if (joy_swap) begin
			joy_out.joy0 = joy_in.joy1;
			joy_out.joy1 = joy_in.joy0;
		end else begin
			joy_out = joy_in;
		end
	end

endmodule

`default_nettype wire

/* sigma_delta_dac.sv */
`timescale 1ns/10ps
`default_nettype none

module sigma_delta_dac (
	input  wire logic        clk_chipset,
	input  wire logic        reset_wire,
	input  wire logic [14:0] level,
	output logic             bitstream
);

	logic [14:0] acc;
	// carry in bit 15
	logic [15:0] sum;

	assign sum = {1'b0, acc} + {1'b0, level};

	// first order, density of ones is level over 2^15
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			acc       <= '0;
			bitstream <= 1'b0;
		end else begin
			acc       <= sum[14:0];
			bitstream <= sum[15];
		end
	end

endmodule

`default_nettype wire

/* sound_mixer.sv */
`timescale 1ns/10ps
`default_nettype none

module sound_mixer import pcxt_pkg::*; (
	input  wire logic               clk_chipset,
	input  wire logic               reset_wire,
	input  wire logic signed [15:0] opl2_snd,
	input  wire logic               speaker,
	input  wire logic [7:0]         tandy_snd,
	output logic [mix_width-1:0]    mix,
	output logic [15:0]             dac_word
);

	logic [mix_width-1:0] opl2_term;
	logic [mix_width-1:0] spk_term;
	logic [mix_width-1:0] tandy_term;

	// opl2 sign-extended
	assign opl2_term  = {opl2_snd[15], opl2_snd};
	// speaker adds 2^14 when low
	assign spk_term   = {2'b00, ~speaker, 14'd0};
	// tandy psg times 512
	assign tandy_term = {tandy_snd, 9'd0};

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			mix <= '0;
		else
			mix <= opl2_term + spk_term + tandy_term;
	end

	// 16-bit dac image, mix over 2
	assign dac_word = mix[mix_width-1:1];

endmodule

`default_nettype wire

/* splash_timer.sv */
`timescale 1ns/10ps
`default_nettype none

module splash_timer import pcxt_pkg::*; #(
	parameter int splash_ticks = splash_ticks_default
) (
	input  wire logic      clk_chipset,
	input  wire logic      reset_wire,
	input  wire logic      ce_14m,
	input  wire settings_t settings,
	output logic           splash_active
);

	// ticks inside one second
	logic [$clog2(splash_ticks + 1)-1:0]   tick_cnt;
	// whole seconds done
	logic [$clog2(splash_seconds + 1)-1:0] sec_cnt;

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			splash_active <= 1'b1;
			tick_cnt      <= '0;
			sec_cnt       <= '0;
		end else if (splash_active) begin
			if (settings.splash_skip) begin
				splash_active <= 1'b0;
			end else if (int'(sec_cnt) == splash_seconds) begin
				splash_active <= 1'b0;
			end else if (ce_14m) begin
				if (int'(tick_cnt) == splash_ticks - 1) begin
					tick_cnt <= '0;
					sec_cnt  <= sec_cnt + 1'b1;
				end else begin
					tick_cnt <= tick_cnt + 1'b1;
				end
			end
		end
	end

endmodule

`default_nettype wire

/* reset_sequencer.sv */
`timescale 1ns/10ps
`default_nettype none

module reset_sequencer import pcxt_pkg::*; (
	input  wire logic      clk_chipset,
	input  wire logic      reset_wire,
	input  wire settings_t settings,
	input  wire logic      splash_active,
	output logic           sys_reset,
	output logic           cpu_reset,
	output logic           tandy_mode
);

	logic cause;
	logic sys_q;
	logic [$clog2(reset_stretch_cycles)-1:0] stretch_cnt;
	logic [$clog2(cpu_reset_delay + 1)-1:0]  cpu_cnt;

	// synchronous causes, reset_wire acts directly
	assign cause = settings.soft_reset | splash_active;

	//////////////////////////////
	// stretched system reset
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_reset   <= 1'b1;
			stretch_cnt <= '0;
		end else if (cause) begin
			sys_reset   <= 1'b1;
			stretch_cnt <= '0;
		end else if (sys_reset) begin
			// hold after the last cause
			if (stretch_cnt == ($bits(stretch_cnt))'(reset_stretch_cycles - 1))
				sys_reset <= 1'b0;
			else
				stretch_cnt <= stretch_cnt + 1'b1;
		end
	end

	//////////////////////////////
	// delayed cpu reset
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sys_q      <= 1'b1;
			cpu_reset  <= 1'b1;
			cpu_cnt    <= '0;
			tandy_mode <= 1'b0;
		end else begin
			sys_q <= sys_reset;
			// machine model sampled while in reset
			if (sys_reset)
				tandy_mode <= settings.tandy;
			// cause sets it on the same edge as sys_reset
			if (cause || sys_q) begin
				cpu_reset <= 1'b1;
				cpu_cnt   <= '0;
			end else if (cpu_reset) begin
				if (cpu_cnt == ($bits(cpu_cnt))'(cpu_reset_delay))
					cpu_reset <= 1'b0;
				else
					cpu_cnt <= cpu_cnt + 1'b1;
			end
		end
	end

	cpu_in_reset: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		sys_reset |-> cpu_reset);

endmodule

`default_nettype wire

/* clock_enable_gen.sv */
`timescale 1ns/10ps
`default_nettype none

module clock_enable_gen import pcxt_pkg::*; (
	input  wire logic      clk_chipset,
	input  wire logic      reset_wire,
	input  wire logic      ref_clk,
	input  wire logic      opl2_clk,
	input  wire logic      uart_clk,
	input  wire settings_t settings,
	input  wire logic      biu_done,
	output rate_ce_t       ce,
	output logic           ce_uart,
	output logic           turbo
);

	// bit 0 ref, bit 1 opl2, bit 2 uart
	logic [2:0] sync_a;
	logic [2:0] sync_b;
	logic [2:0] sync_c;
	logic [2:0] edge_q;
	// divider bank state, one slot per rate
	logic [3:0] div_cnt [4];
	logic [3:0] rate_hit;
	logic [$clog2(uart_slow_div)-1:0] uart_cnt;

	//////////////////////////////
	// input synchronisers
	//////////////////////////////

	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			sync_a <= '0;
			sync_b <= '0;
			sync_c <= '0;
			edge_q <= '0;
		end else begin
			sync_a <= {uart_clk, opl2_clk, ref_clk};
			sync_b <= sync_a;
			sync_c <= sync_b;
			// rising edge, one cycle wide
			edge_q <= sync_b & ~sync_c;
		end
	end

	//////////////////////////////
	// reference dividers
	//////////////////////////////

	for (genvar i = 0; i < 4; i++) begin : g_div
		always_ff @(posedge clk_chipset or posedge reset_wire) begin
			if (reset_wire) begin
				div_cnt[i] <= '0;
			end else if (edge_q[0]) begin
				if (div_cnt[i] == 4'(rate_divs[i] - 1))
					div_cnt[i] <= '0;
				else
					div_cnt[i] <= div_cnt[i] + 4'd1;
			end
		end
		// last edge of each count period
		assign rate_hit[i] = edge_q[0] && (div_cnt[i] == 4'(rate_divs[i] - 1));
	end

	// uart edge thinning counter
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			uart_cnt <= '0;
		else if (edge_q[2])
			uart_cnt <= uart_cnt + 1'b1;
	end

	always_comb begin
		ce.ce_14m    = rate_hit[0];
		ce.ce_7m     = rate_hit[1];
		ce.ce_4m77   = rate_hit[2];
		ce.ce_periph = rate_hit[3];
		// cpu rate from the speed field
		case (settings.cpu_speed)
			2'd1: ce.ce_cpu = rate_hit[1];
			2'd2: ce.ce_cpu = rate_hit[0];
			default: ce.ce_cpu = rate_hit[2];
		endcase
		ce.ce_opl2 = edge_q[1];
		ce_uart = edge_q[2] &&
			(settings.uart_fast || uart_cnt == ($bits(uart_cnt))'(uart_slow_div - 1));
	end

	// turbo only moves between bus cycles
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire)
			turbo <= 1'b0;
		else if (biu_done)
			turbo <= (settings.cpu_speed == 2'd1) || (settings.cpu_speed == 2'd2);
	end

	ce_14m_gap: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		ce.ce_14m |=> !ce.ce_14m);

endmodule

`default_nettype wire

/* config_port.sv */
`timescale 1ns/10ps
`default_nettype none

module config_port import pcxt_pkg::*; (
	input  wire logic     clk_chipset,
	input  wire logic     reset_wire,
	input  wire cfg_req_t cfg,
	output logic          cfg_ack,
	output settings_t     settings
);

	typedef enum logic {
		st_idle,
		st_ack
	} state_t;

	state_t    state;
	settings_t decoded;

	// field map of the option word
	always_comb begin
		decoded.soft_reset  = cfg.word[0];
		decoded.tandy       = cfg.word[3];
		decoded.mda         = cfg.word[4];
		decoded.splash_skip = cfg.word[7];
		decoded.cpu_speed   = cfg.word[18:17];
		// any non-zero uart field picks the fast range
		decoded.uart_fast   = |cfg.word[22:21];
	end

	// four-phase receiver
	always_ff @(posedge clk_chipset or posedge reset_wire) begin
		if (reset_wire) begin
			state    <= st_idle;
			settings <= '0;
		end else begin
			case (state)
				st_idle: if (cfg.req) begin
					// word is stable while req is up
					settings <= decoded;
					state    <= st_ack;
				end
				st_ack: if (!cfg.req) state <= st_idle;
				default: state <= st_idle;
			endcase
		end
	end

	assign cfg_ack = (state == st_ack);

	// ack only ever answers a pending request
	ack_needs_req: assert property (@(posedge clk_chipset) disable iff (reset_wire)
		$rose(cfg_ack) |-> $past(cfg.req));

endmodule

`default_nettype wire

/* pcxt_pkg.sv */
`default_nettype none

package pcxt_pkg;

	//////////////////////////////
	// widths and counts
	//////////////////////////////

	// host option word
	localparam int status_width = 32;
	// sys reset hold after the last cause, short for simulation
	localparam int reset_stretch_cycles = 16;
	// cpu reset hold after sys reset drops
	localparam int cpu_reset_delay = 42;
	// splash hold-off
	localparam int splash_seconds = 5;
	localparam int splash_ticks_default = 14318000;

	// pc/xt dip switch images
	localparam logic [7:0] sw_cga = 8'h2D;
	localparam logic [7:0] sw_mda = 8'h3D;

	// reference edges per enable pulse, 28.636 mhz in
	localparam int div_14m = 2;
	localparam int div_7m = 4;
	localparam int div_4m77 = 6;
	localparam int div_periph = 12;
	// same ratios indexed as the divider bank uses them
	localparam int rate_divs [4] = '{div_14m, div_7m, div_4m77, div_periph};

	// uart enable thinning at slow rate
	localparam int uart_slow_div = 8;

	// sound mix word
	localparam int mix_width = 17;

	//////////////////////////////
	// shared structs
	//////////////////////////////

	// decoded option fields
	typedef struct packed {
		logic       soft_reset;
		logic       tandy;
		logic       mda;
		logic       splash_skip;
		// 0 and 3 are 4.77, 1 is 7.16, 2 is 14.318
		logic [1:0] cpu_speed;
		logic       uart_fast;
	} settings_t;

	// one-cycle rate enables
	typedef struct packed {
		logic ce_14m;
		logic ce_7m;
		logic ce_4m77;
		logic ce_periph;
		logic ce_cpu;
		logic ce_opl2;
	} rate_ce_t;

	typedef struct packed {
		logic [31:0] joy0;
		logic [31:0] joy1;
	} joy_pair_t;

	// host side of the config handshake
	typedef struct packed {
		logic                    req;
		logic [status_width-1:0] word;
	} cfg_req_t;

endpackage

`default_nettype wire
